// File: biquad_lpf.f
+incdir+src
src/biquad_pkg.sv
src/biquad_ctrl_if.sv
src/coef_regs.sv
src/warmup_timer.sv
src/biquad_sequencer.sv
src/biquad_datapath.sv
src/biquad_lpf_top.sv
bench/biquad_lpf_tb.sv

// File: bench/biquad_lpf_tb.sv
// Biquad low-pass testbench
// Four-phase source and sink, coefficient writes, reference model and checks
`include "biquad_cfg.svh"

module biquad_lpf_tb import biquad_pkg::*; ();

  localparam logic [31:0] LFSR_SEED = 32'h44913357;
  localparam logic [31:0] LFSR_MASK = 32'h80200003;
  // Sample count over all tests for the watchdog
  localparam int TOTAL_SAMPLES = 336;

  logic clk = 1'b0;
  logic rst_n, x_req, x_ack, y_req, y_ack, cfg_we;
  sample_t x, y;
  coef_addr_t cfg_addr;
  coef_t cfg_data;

  // Reference delay line, coefficient sets and warm-up count
  sample_t ref_w1, ref_w2;
  coef_t ref_act[3];
  coef_t ref_sh[3];
  logic ref_pending;
  int ref_warm;

  sample_t exp_q[$];
  int dly_q[$];
  sample_t exp_v;
  string test_name = "reset";
  logic [31:0] lfsr_state;
  int checks = 0, mismatches = 0, errors = 0, out_count = 0, base;
  int ack_delay = 0, ack_cnt = 0;
  logic out_seen = 1'b0, y_req_d = 1'b0, x_ack_d = 1'b0;

  biquad_lpf_top biquad_lpf_top_inst (
    .clk(clk), .rst_n(rst_n), .x_req(x_req), .x(x), .x_ack(x_ack),
    .y_req(y_req), .y(y), .y_ack(y_ack),
    .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_data(cfg_data)
  );

  always #50 clk = ~clk;

  ////////////////////////////////////////
  // Random numbers and reference model
  ////////////////////////////////////////

  // One bit out per Galois step
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_MASK) : (lfsr_state >> 1);
    end
    rand_bits = r;
  endfunction

  // Keeps bits 29..14 of the Q14 product
  function automatic sample_t q_slice(input coef_t c, input sample_t v);
    product_t p;
    p = c * v;
    q_slice = p[`BQ_Q_BITS +: `BQ_DATA_W];
  endfunction

  // Direct form II step with all sums wrapping at 16 bits
  function automatic sample_t ref_filter(input sample_t xv);
    sample_t w, s;
    w = xv - q_slice(ref_act[0], ref_w1) - q_slice(ref_act[1], ref_w2);
    s = w + ref_w1 + ref_w1 + ref_w2;
    ref_w2 = ref_w1;
    ref_w1 = w;
    ref_filter = q_slice(ref_act[2], s);
  endfunction

  ////////////////////////////////////////
  // Monitor and sink
  ////////////////////////////////////////

  // Sampled mid-cycle away from the driving edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (y_req && !y_req_d) begin
        out_count++;
        ack_delay = 0;
        if (exp_q.size() == 0) begin
          errors++;
          $display("ERROR %s: output %0d appeared where suppression was expected", test_name, y);
        end else begin
          exp_v = exp_q.pop_front();
          ack_delay = dly_q.pop_front();
          checks++;
          if (y !== exp_v) begin
            mismatches++;
            $display("MISMATCH %s: expected %0d, actual %0d", test_name, exp_v, y);
          end
        end
        out_seen = 1'b1;
      end
      // A new x_ack only once the output side is quiet
      if (x_ack && !x_ack_d && (y_req || y_ack)) begin
        errors++;
        $display("ERROR %s: x_ack rose while the previous output handshake was open", test_name);
      end
      y_req_d = y_req;
      x_ack_d = x_ack;
    end
  end

  // Sink answers y_req after the delay chosen for that sample
  always begin
    @(posedge clk);
    #5;
    if (y_req && !y_ack && out_seen) begin
      if (ack_cnt >= ack_delay) begin
        y_ack = 1'b1;
        ack_cnt = 0;
        out_seen = 1'b0;
      end else begin
        ack_cnt++;
      end
    end else if (!y_req && y_ack) begin
      y_ack = 1'b0;
    end
  end

  ////////////////////////////////////////
  // Driver tasks
  ////////////////////////////////////////

  task automatic cfg_write(input coef_addr_t addr, input coef_t data);
    cfg_we = 1'b1;
    cfg_addr = addr;
    cfg_data = data;
    @(posedge clk);
    #5;
    cfg_we = 1'b0;
    // Address 3 has no register
    if (addr != 2'd3) begin
      ref_sh[addr] = data;
      ref_pending = 1'b1;
    end
  endtask

  task automatic send_sample(input sample_t xv, input logic slow_sink);
    sample_t exp_y;
    int dly, t;
    // New set goes live in idle right before this sample
    if (ref_pending) begin
      ref_act = ref_sh;
      ref_pending = 1'b0;
      ref_warm = `BQ_WARMUP;
    end
    exp_y = ref_filter(xv);
    dly = slow_sink ? int'(rand_bits(3)) : 0;
    if (ref_warm != 0) begin
      ref_warm--;
    end else begin
      exp_q.push_back(exp_y);
      dly_q.push_back(dly);
    end
    x = xv;
    x_req = 1'b1;
    t = 0;
    do begin
      @(posedge clk);
      #5;
      t++;
    end while (!x_ack && t < 100);
    if (!x_ack) begin
      errors++;
      $display("ERROR %s: x_ack never rose for input %0d", test_name, xv);
    end
    x_req = 1'b0;
    t = 0;
    do begin
      @(posedge clk);
      #5;
      t++;
    end while (x_ack && t < 100);
    if (x_ack) begin
      errors++;
      $display("ERROR %s: x_ack stayed high after x_req fell", test_name);
    end
  endtask

  // Let the last output finish, then count what never came
  task automatic drain(input int want);
    int t;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while ((exp_q.size() != 0 || y_req || y_ack) && t < 60);
    if (exp_q.size() != 0) begin
      errors += exp_q.size();
      $display("ERROR %s: %0d expected outputs never appeared", test_name, exp_q.size());
      exp_q.delete();
      dly_q.delete();
    end
    if (out_count - base != want) begin
      errors++;
      $display("ERROR %s: saw %0d outputs, wanted %0d", test_name, out_count - base, want);
    end
    base = out_count;
    @(posedge clk);
    #5;
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    rst_n = 1'b0;
    x_req = 1'b0;
    x = '0;
    y_ack = 1'b0;
    cfg_we = 1'b0;
    cfg_addr = '0;
    cfg_data = '0;
    lfsr_state = LFSR_SEED;
    ref_w1 = '0;
    ref_w2 = '0;
    // Reset set in Q14 with a1 = -0.5, a2 = 0.25 and k = 0.25
    ref_act[0] = -16'sd8192;
    ref_act[1] = 16'sd4096;
    ref_act[2] = 16'sd4096;
    ref_sh = ref_act;
    ref_pending = 1'b0;
    ref_warm = `BQ_WARMUP;
    base = 0;
    repeat (3) @(posedge clk);
    #5;
    rst_n = 1'b1;

    // Zeros cover the warm-up, then impulse and step
    test_name = "impulse_step";
    repeat (4) send_sample('0, 1'b0);
    send_sample(16'sd8192, 1'b0);
    repeat (11) send_sample('0, 1'b0);
    repeat (12) send_sample(16'sd4000, 1'b0);
    drain(28 - `BQ_WARMUP);

    test_name = "lfsr_prompt";
    repeat (200) send_sample(sample_t'(rand_bits(16)), 1'b0);
    drain(200);

    test_name = "back_pressure";
    repeat (60) send_sample(sample_t'(rand_bits(16)), 1'b1);
    drain(60);

    // a1 = -0.6, a2 = 0.2, k = 0.15
    test_name = "coef_change";
    cfg_write(2'd0, -16'sd9830);
    cfg_write(2'd1, 16'sd3277);
    cfg_write(2'd2, 16'sd2458);
    repeat (12) send_sample(sample_t'(rand_bits(16)), 1'b1);
    drain(12 - `BQ_WARMUP);

    // No register behind address 3, so no warm-up either
    test_name = "addr3_ignored";
    cfg_write(2'd3, 16'sh7FFF);
    repeat (12) send_sample(sample_t'(rand_bits(16)), 1'b0);
    drain(12);

    // Near full scale everywhere for heavy wrap
    test_name = "full_scale";
    cfg_write(2'd0, 16'sh8001);
    cfg_write(2'd1, 16'sh7FFF);
    cfg_write(2'd2, 16'sh7FFF);
    for (int i = 0; i < 8; i++) begin
      send_sample((i % 2) ? 16'sh8000 : 16'sh7FFF, 1'b1);
    end
    repeat (16) send_sample(sample_t'(rand_bits(16)), 1'b1);
    drain(24 - `BQ_WARMUP);

    $display("checks %0d, mismatches %0d, errors %0d", checks, mismatches, errors);
    if (mismatches == 0 && errors == 0 && checks > 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog allows 40 cycles per sample plus margin
  initial begin
    #((TOTAL_SAMPLES * 40 + 600) * 100);
    errors++;
    $display("ERROR %s: run did not finish in time, DUT stopped responding", test_name);
    $display("checks %0d, mismatches %0d, errors %0d", checks, mismatches, errors);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: src/biquad_lpf_top.sv
// Biquad low-pass filter top
// Four-phase sample input and output, coefficient write port
module biquad_lpf_top import biquad_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       x_req,
  input  sample_t    x,
  output logic       x_ack,
  output logic       y_req,
  output sample_t    y,
  input  logic       y_ack,
  input  logic       cfg_we,
  input  coef_addr_t cfg_addr,
  input  coef_t      cfg_data
);

  // Active coefficients
  coef_t a1;
  coef_t a2;
  coef_t k;
  // Apply and warm-up control
  logic  pending;
  logic  apply;
  logic  suppress;
  logic  sample_done;

  biquad_ctrl_if ctrl_bus ();

  coef_regs coef_regs_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .cfg_we   (cfg_we),
    .cfg_addr (cfg_addr),
    .cfg_data (cfg_data),
    .apply    (apply),
    .pending  (pending),
    .a1       (a1),
    .a2       (a2),
    .k        (k)
  );

  // Restarted by every apply
  warmup_timer warmup_timer_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .restart     (apply),
    .sample_done (sample_done),
    .suppress    (suppress)
  );

  biquad_sequencer biquad_sequencer_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .x_req       (x_req),
    .x_ack       (x_ack),
    .y_req       (y_req),
    .y_ack       (y_ack),
    .pending     (pending),
    .apply       (apply),
    .suppress    (suppress),
    .sample_done (sample_done),
    .ctrl        (ctrl_bus.seq)
  );

  biquad_datapath biquad_datapath_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .x     (x),
    .a1    (a1),
    .a2    (a2),
    .k     (k),
    .ctrl  (ctrl_bus.dp)
  );

  // Valid while y_req is high
  assign y = ctrl_bus.result;

endmodule

// File: src/biquad_datapath.sv
// Biquad datapath
// Delay line, shared multiplier, Q slicing and accumulator for w(n) and y(n)
`include "biquad_cfg.svh"

module biquad_datapath import biquad_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  sample_t x,
  input  coef_t   a1,
  input  coef_t   a2,
  input  coef_t   k,
  biquad_ctrl_if.dp ctrl
);

  // Delay line w(n-1), w(n-2)
  sample_t  w1;
  sample_t  w2;
  // Working registers
  sample_t  x_r;
  sample_t  w;
  sample_t  psum;
  sample_t  y_r;
  product_t prod;

  coef_t    mul_a;
  sample_t  mul_b;
  product_t mul_p;
  sample_t  prod_slice;

  ////////////////////////////////////////
  // Shared multiplier
  ////////////////////////////////////////

  // Operand select per stage
  always_comb begin
    case (ctrl.op)
      op_load_x: begin
        mul_a = a1;
        mul_b = w1;
      end
      op_sub_a1: begin
        mul_a = a2;
        mul_b = w2;
      end
      op_gain: begin
        mul_a = k;
        mul_b = psum;
      end
      default: begin
        mul_a = '0;
        mul_b = '0;
      end
    endcase
  end

  assign mul_p = mul_a * mul_b;

  // Drop fraction bits, then keep the sample width
  assign prod_slice = sample_t'(prod >>> `BQ_Q_BITS);

  ////////////////////////////////////////
  // Accumulator and output
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    case (ctrl.op)
      op_load_x: begin
        x_r  <= x;
        prod <= mul_p;
      end
      op_sub_a1: begin
        w    <= x_r - prod_slice;
        prod <= mul_p;
      end
      op_sub_a2: w <= w - prod_slice;
      // Fixed numerator 1, 2, 1
      op_sum:  psum <= w + sample_t'(w1 <<< 1) + w2;
      op_gain: prod <= mul_p;
      // y only moves here so it holds through the output handshake
      op_out:  y_r <= prod_slice;
      default: ;
    endcase
  end

  // Delay line shifts with the output stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w1 <= '0;
      w2 <= '0;
    end else if (ctrl.op == op_out) begin
      w2 <= w1;
      w1 <= w;
    end
  end

  assign ctrl.result = y_r;

endmodule

// File: src/biquad_sequencer.sv
// Biquad sequencer
// Runs both four-phase handshakes, the apply point and the stage commands
module biquad_sequencer import biquad_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic x_req,
  output logic x_ack,
  output logic y_req,
  input  logic y_ack,
  input  logic pending,
  output logic apply,
  input  logic suppress,
  output logic sample_done,
  biquad_ctrl_if.seq ctrl
);

  seq_state_t state;
  // Result of the current sample is dropped
  logic drop_y;

  ////////////////////////////////////////
  // Command decode
  ////////////////////////////////////////

  // One op per computing state, acted on at the edge that leaves it
  always_comb begin
    case (state)
      load:    ctrl.op = op_load_x;
      sub_a1:  ctrl.op = op_sub_a1;
      sub_a2:  ctrl.op = op_sub_a2;
      sum:     ctrl.op = op_sum;
      gain:    ctrl.op = op_gain;
      out:     ctrl.op = op_out;
      default: ctrl.op = op_none;
    endcase
  end

  // Coefficient transfer only between samples
  // Idle with a pending set costs one cycle
  assign apply = (state == idle) && pending;

  ////////////////////////////////////////
  // State machine and handshakes
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= idle;
      x_ack       <= 1'b0;
      y_req       <= 1'b0;
      sample_done <= 1'b0;
      drop_y      <= 1'b0;
    end else begin
      sample_done <= 1'b0;
      case (state)
        idle: begin
          // Pending coefficients win over a new sample
          if (!pending && x_req) begin
            state <= load;
          end
        end
        load:   state <= sub_a1;
        sub_a1: state <= sub_a2;
        sub_a2: state <= sum;
        sum:    state <= gain;
        gain:   state <= out;
        out: begin
          // Decide release now, x is long captured
          drop_y <= suppress;
          x_ack  <= 1'b1;
          state  <= hold;
        end
        hold: state <= wait_x_low;
        wait_x_low: begin
          // Close the input handshake
          if (!x_req) begin
            x_ack       <= 1'b0;
            sample_done <= 1'b1;
            if (drop_y) begin
              state <= idle;
            end else begin
              y_req <= 1'b1;
              state <= wait_y_ack;
            end
          end
        end
        wait_y_ack: begin
          if (y_ack) begin
            y_req <= 1'b0;
            state <= wait_y_low;
          end
        end
        wait_y_low: begin
          // Next x_req is only seen after the sink lets go
          if (!y_ack) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

// File: src/warmup_timer.sv
// Warm-up timer
// Flags results as settling transient after reset or a coefficient change
`include "biquad_cfg.svh"

module warmup_timer (
  input  logic clk,
  input  logic rst_n,
  input  logic restart,
  input  logic sample_done,
  output logic suppress
);

  // Remaining results to hold back
  logic [`BQ_WARMUP-1:0] cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= `BQ_WARMUP;
    end else if (restart) begin
      // New coefficients restart the transient
      cnt <= `BQ_WARMUP;
    end else if (sample_done && (cnt != '0)) begin
      cnt <= cnt - 1'b1;
    end
  end

  // Nonzero count means the coming result is not released
  assign suppress = (cnt != '0);

endmodule

// File: src/coef_regs.sv
// Coefficient register bank
// Shadow set written by the host, copied to the active set between samples
`include "biquad_cfg.svh"

module coef_regs import biquad_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cfg_we,
  input  coef_addr_t cfg_addr,
  input  coef_t      cfg_data,
  input  logic       apply,
  output logic       pending,
  output coef_t      a1,
  output coef_t      a2,
  output coef_t      k
);

  // Default low-pass set in Q format
  // a1 = -0.5, a2 = 0.25, k = 0.25
  localparam coef_t A1_INIT = coef_t'(-(1 << (`BQ_Q_BITS - 1)));
  localparam coef_t A2_INIT = coef_t'(1 << (`BQ_Q_BITS - 2));
  localparam coef_t K_INIT  = coef_t'(1 << (`BQ_Q_BITS - 2));

  coef_t sh_a1;
  coef_t sh_a2;
  coef_t sh_k;
  logic  wr_hit;

  // Address 3 decodes to nothing
  assign wr_hit = cfg_we && (cfg_addr != coef_addr_t'(3));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sh_a1   <= A1_INIT;
      sh_a2   <= A2_INIT;
      sh_k    <= K_INIT;
      a1      <= A1_INIT;
      a2      <= A2_INIT;
      k       <= K_INIT;
      pending <= 1'b0;
    end else begin
      // Host writes go to the shadow copy only
      if (cfg_we) begin
        case (cfg_addr)
          coef_addr_t'(0): sh_a1 <= cfg_data;
          coef_addr_t'(1): sh_a2 <= cfg_data;
          coef_addr_t'(2): sh_k  <= cfg_data;
          default: ;
        endcase
      end
      // Transfer at the sequencer's apply point
      if (apply) begin
        a1 <= sh_a1;
        a2 <= sh_a2;
        k  <= sh_k;
      end
      // A write racing the apply stays pending for the next one
      if (wr_hit) begin
        pending <= 1'b1;
      end else if (apply) begin
        pending <= 1'b0;
      end
    end
  end

endmodule

// File: src/biquad_ctrl_if.sv
// Biquad control bus
// Stage commands from the sequencer and the result back from the datapath
interface biquad_ctrl_if import biquad_pkg::*; ();

  // One-cycle command, executed by the datapath at the next edge
  bq_op_t  op;

  // Current y register of the datapath
  sample_t result;

  ////////////////////////////////////////
  // Sequencer side
  ////////////////////////////////////////

  // Issues one command per computing state
  modport seq (
    output op
  );

  ////////////////////////////////////////
  // Datapath side
  ////////////////////////////////////////

  // Follows the commands and presents y
  modport dp (
    input  op,
    output result
  );

endinterface

// File: src/biquad_pkg.sv
// Biquad shared types
// Vector typedefs plus datapath command and sequencer state encodings
`include "biquad_cfg.svh"

package biquad_pkg;

  // Samples, w values and partial sums
  typedef logic signed [`BQ_DATA_W-1:0] sample_t;
  // Q-format coefficient
  typedef logic signed [`BQ_DATA_W-1:0] coef_t;
  // Full-width multiplier result
  typedef logic signed [2*`BQ_DATA_W-1:0] product_t;
  // 0 is a1, 1 is a2, 2 is k
  typedef logic [`BQ_ADDR_W-1:0] coef_addr_t;

  // Datapath commands, one per computing stage
  typedef enum logic [2:0] {
    op_none,
    op_load_x,
    op_sub_a1,
    op_sub_a2,
    op_sum,
    op_gain,
    op_out
  } bq_op_t;

  // Sequencer states
  typedef enum logic [3:0] {
    idle, load, sub_a1, sub_a2, sum, gain, out,
    hold, wait_x_low, wait_y_ack, wait_y_low
  } seq_state_t;

endpackage

// File: src/biquad_cfg.svh
// Biquad low-pass configuration
// Sample width, coefficient format, warm-up length and address width
`ifndef BIQUAD_CFG_SVH
`define BIQUAD_CFG_SVH

// Width of samples and coefficients
`define BQ_DATA_W 16

// Fraction bits of the Q-format coefficients
`define BQ_Q_BITS 14

// Results held back after reset or a coefficient change
`define BQ_WARMUP 4

// Coefficient write address width
`define BQ_ADDR_W 2

`endif
